// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - src/lsu_bus_pkg.sv
      - src/lsu_ctrl_pkg.sv
      - src/lsu_req_align.sv
      - src/lsu_rdata_align.sv
      - src/lsu_ctrl_fsm.sv
      - src/lsu_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/tb_lsu_mem.sv
      - tb/lsu_asserts.sv
      - tb/tb_lsu.sv

// ==== src/lsu_bus_pkg.sv ====
/*
 * Widths and vector types of the data bus and byte addresses.
 * Imported by the alignment units, the sequencer and the top level.
 */

`default_nettype none

package lsu_bus_pkg;

  // byte addresses and data words of the bus
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  // one enable per byte lane
  localparam int unsigned NUM_BYTES = DATA_W / 8;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    word_t;
  typedef logic [NUM_BYTES-1:0] be_t;

  // byte position inside one word
  typedef logic [$clog2(NUM_BYTES)-1:0] offset_t;

endpackage

`default_nettype wire

// ==== src/lsu_ctrl_fsm.sv ====
/*
 * Access sequencer of the load/store unit. Issues one or two word-aligned
 * bus requests per access, asks the core for the next word address, tracks
 * bus errors and the last address, and drives the response outputs.
 */

`default_nettype none

module lsu_ctrl_fsm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               lsu_req_i,
  input  logic               lsu_we_i,
  input  logic               split_i,
  input  lsu_bus_pkg::addr_t data_addr_i,
  input  lsu_bus_pkg::addr_t data_addr_aligned_i,
  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               data_err_i,

  output logic               data_req_o,
  output logic               addr_incr_req_o,
  output logic               second_part_o,
  output logic               ctrl_update_o,
  output logic               rdata_update_o,
  output lsu_bus_pkg::addr_t addr_last_o,
  output logic               lsu_req_done_o,
  output logic               lsu_resp_valid_o,
  output logic               lsu_rdata_valid_o,
  output logic               load_err_o,
  output logic               store_err_o,
  output logic               busy_o
);

  import lsu_bus_pkg::*;
  import lsu_ctrl_pkg::*;

  ls_fsm_e ls_fsm_cs, ls_fsm_ns;

  // set from first grant of a split access until its second grant
  logic    handle_mis_q, handle_mis_d;
  // first half of a split access saw a bus error
  logic    lsu_err_q, lsu_err_d;
  logic    we_q;
  logic    addr_update;
  addr_t   addr_last_q, addr_last_d;
  logic    err_any;

  ////////////////////////////////////////////////////////////////////////////
  // sequencer
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ls_fsm_ns       = ls_fsm_cs;
    handle_mis_d    = handle_mis_q;
    lsu_err_d       = lsu_err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    unique case (ls_fsm_cs)
      LS_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          lsu_err_d  = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            handle_mis_d  = split_i;
            ls_fsm_ns     = split_i ? LS_WAIT_RVALID_MIS : LS_IDLE;
          end else begin
            ls_fsm_ns     = split_i ? LS_WAIT_GNT_MIS : LS_WAIT_GNT;
          end
        end
      end

      // first half of a split access still waiting for its grant
      LS_WAIT_GNT_MIS: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          handle_mis_d  = 1'b1;
          ls_fsm_ns     = LS_WAIT_RVALID_MIS;
        end
      end

      // second request goes out while the first response is pending
      // core holds first address plus 4 meanwhile
      LS_WAIT_RVALID_MIS: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          rdata_update_o = ~we_q;
          // keep the first failing address
          addr_update    = data_gnt_i & ~data_err_i;
          handle_mis_d   = ~data_gnt_i;
          ls_fsm_ns      = data_gnt_i ? LS_IDLE : LS_WAIT_GNT;
        end else if (data_gnt_i) begin
          handle_mis_d = 1'b0;
          ls_fsm_ns    = LS_WAIT_RVALID_MIS_GNTS_DONE;
        end
      end

      // single request, or second half of a split one, waiting for grant
      LS_WAIT_GNT: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = handle_mis_q;
        if (data_gnt_i) begin
          // attributes of a split access were taken at its first grant
          ctrl_update_o = ~handle_mis_q;
          addr_update   = ~lsu_err_q;
          handle_mis_d  = 1'b0;
          ls_fsm_ns     = LS_IDLE;
        end
      end

      // both grants seen, first response outstanding
      LS_WAIT_RVALID_MIS_GNTS_DONE: begin
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          lsu_err_d      = data_err_i;
          rdata_update_o = ~we_q;
          addr_update    = ~data_err_i;
          ls_fsm_ns      = LS_IDLE;
        end
      end

      default: begin
        ls_fsm_ns = LS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ls_fsm_cs    <= LS_IDLE;
      handle_mis_q <= 1'b0;
      lsu_err_q    <= 1'b0;
    end else begin
      ls_fsm_cs    <= ls_fsm_ns;
      handle_mis_q <= handle_mis_d;
      lsu_err_q    <= lsu_err_d;
    end
  end

  // load or store, decides which error output fires
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= lsu_we_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // last address for the trap value
  ////////////////////////////////////////////////////////////////////////////

  // second half reports its word-aligned address
  assign addr_last_d = addr_incr_req_o ? data_addr_aligned_i : data_addr_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_last_d;
    end
  end

  assign addr_last_o = addr_last_q;

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////

  assign second_part_o  = handle_mis_q;
  assign lsu_req_done_o = (lsu_req_i | (ls_fsm_cs != LS_IDLE)) & (ls_fsm_ns == LS_IDLE);

  // final response always arrives back in idle
  assign err_any           = lsu_err_q | data_err_i;
  assign lsu_resp_valid_o  = data_rvalid_i & (ls_fsm_cs == LS_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~err_any & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & err_any & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & err_any & we_q;
  assign busy_o            = (ls_fsm_cs != LS_IDLE);

endmodule

`default_nettype wire

// ==== src/lsu_ctrl_pkg.sv ====
/*
 * Access-size encoding from the execute stage and the states of the
 * access sequencer.
 */

`default_nettype none

package lsu_ctrl_pkg;

  // access size as decoded by the core
  // both byte codes select a single byte
  typedef enum logic [1:0] {
    LSU_WORD     = 2'b00,
    LSU_HALF     = 2'b01,
    LSU_BYTE     = 2'b10,
    LSU_BYTE_ALT = 2'b11
  } lsu_type_e;

  // sequencer states
  // the MIS states belong to an access split in two bus requests
  typedef enum logic [2:0] {
    LS_IDLE,
    LS_WAIT_GNT_MIS,
    LS_WAIT_RVALID_MIS,
    LS_WAIT_GNT,
    LS_WAIT_RVALID_MIS_GNTS_DONE
  } ls_fsm_e;

endpackage

`default_nettype wire

// ==== src/lsu_rdata_align.sv ====
/*
 * Load result path. Keeps the first word of a split load, realigns the
 * bytes of the addressed value and zero- or sign-extends it. The result is
 * combinational on the bus read data, valid with the response.
 */

`default_nettype none

module lsu_rdata_align (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    ctrl_update_i,
  input  logic                    rdata_update_i,
  input  lsu_bus_pkg::offset_t    offset_i,
  input  lsu_ctrl_pkg::lsu_type_e lsu_type_i,
  input  logic                    lsu_sign_ext_i,
  input  lsu_bus_pkg::word_t      data_rdata_i,

  output lsu_bus_pkg::word_t      lsu_rdata_o
);

  import lsu_bus_pkg::*;
  import lsu_ctrl_pkg::*;

  // access attributes held until the last response
  offset_t             offset_q;
  lsu_type_e           type_q;
  logic                sign_ext_q;
  // upper three bytes of the first word of a split load
  logic [DATA_W-1:8]   rdata_hi_q;

  word_t               word_w;
  word_t               shifted_w;
  logic [15:0]         half_w;
  logic [7:0]          byte_w;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_hi_q <= data_rdata_i[DATA_W-1:8];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////////////

  // low bytes from the first word, high bytes from the current one
  always_comb begin
    unique case (offset_q)
      2'd1:    word_w = {data_rdata_i[7:0], rdata_hi_q[31:8]};
      2'd2:    word_w = {data_rdata_i[15:0], rdata_hi_q[31:16]};
      2'd3:    word_w = {data_rdata_i[23:0], rdata_hi_q[31:24]};
      default: word_w = data_rdata_i;
    endcase
  end

  // addressed byte moved down to lane 0
  assign shifted_w = data_rdata_i >> {offset_q, 3'b000};

  // halfword at offset 3 straddles both words
  assign half_w = (offset_q == 2'd3) ? word_w[15:0] : shifted_w[15:0];
  assign byte_w = shifted_w[7:0];

  ////////////////////////////////////////////////////////////////////////////
  // extension
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (type_q)
      LSU_WORD:               lsu_rdata_o = word_w;
      LSU_HALF:               lsu_rdata_o = {{16{sign_ext_q & half_w[15]}}, half_w};
      LSU_BYTE, LSU_BYTE_ALT: lsu_rdata_o = {{24{sign_ext_q & byte_w[7]}}, byte_w};
      default:                lsu_rdata_o = word_w;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/lsu_req_align.sv ====
/*
 * Request side of the load/store unit. Builds byte enables, rotates store
 * data onto its byte lanes, word-aligns the bus address and flags accesses
 * that must be split in two bus requests.
 */

`default_nettype none

module lsu_req_align (
  input  lsu_bus_pkg::addr_t     adder_result_ex_i,
  input  lsu_ctrl_pkg::lsu_type_e lsu_type_i,
  input  lsu_bus_pkg::word_t     lsu_wdata_i,
  input  logic                   second_part_i,

  output lsu_bus_pkg::be_t       data_be_o,
  output lsu_bus_pkg::word_t     data_wdata_o,
  output lsu_bus_pkg::addr_t     data_addr_aligned_o,
  output logic                   split_o,
  output lsu_bus_pkg::offset_t   offset_o
);

  import lsu_bus_pkg::*;
  import lsu_ctrl_pkg::*;

  offset_t                 offset;
  // lanes touched by the access if it started at offset 0
  be_t                     be_base;
  // enables over two words, low half first request, high half second
  logic [2*NUM_BYTES-1:0]  be_wide;
  // store data doubled up so a shift gives the rotation
  logic [2*DATA_W-1:0]     wdata_wide;

  assign offset = offset_t'(adder_result_ex_i);

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD:               be_base = 4'b1111;
      LSU_HALF:               be_base = 4'b0011;
      LSU_BYTE, LSU_BYTE_ALT: be_base = 4'b0001;
      default:                be_base = 4'b1111;
    endcase
  end

  // lanes that run past the word end land in the upper half
  assign be_wide   = {{NUM_BYTES{1'b0}}, be_base} << offset;
  assign data_be_o = second_part_i ? be_wide[2*NUM_BYTES-1:NUM_BYTES]
                                   : be_wide[NUM_BYTES-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // write data rotation
  ////////////////////////////////////////////////////////////////////////////

  // rotate left by offset bytes
  // same word serves both halves of a split store
  assign wdata_wide   = {lsu_wdata_i, lsu_wdata_i} << {offset, 3'b000};
  assign data_wdata_o = wdata_wide[2*DATA_W-1:DATA_W];

  ////////////////////////////////////////////////////////////////////////////
  // address and split detection
  ////////////////////////////////////////////////////////////////////////////

  assign data_addr_aligned_o = adder_result_ex_i & ~addr_t'(NUM_BYTES - 1);
  assign offset_o            = offset;

  // word at any nonzero offset, halfword crossing into the next word
  assign split_o = ((lsu_type_i == LSU_WORD) && (offset != 2'd0)) ||
                   ((lsu_type_i == LSU_HALF) && (offset == 2'd3));

endmodule

`default_nettype wire

// ==== src/lsu_top.sv ====
/*
 * Load/store unit top level. Connects the request aligner, the load
 * result aligner and the access sequencer to the core and data bus ports.
 */

`default_nettype none

module lsu_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // execute stage
  input  logic                    lsu_req_i,
  input  logic                    lsu_we_i,
  input  lsu_ctrl_pkg::lsu_type_e lsu_type_i,
  input  lsu_bus_pkg::word_t      lsu_wdata_i,
  input  logic                    lsu_sign_ext_i,
  input  lsu_bus_pkg::addr_t      adder_result_ex_i,
  output lsu_bus_pkg::word_t      lsu_rdata_o,
  output logic                    lsu_rdata_valid_o,
  output logic                    addr_incr_req_o,
  output lsu_bus_pkg::addr_t      addr_last_o,
  output logic                    lsu_req_done_o,
  output logic                    lsu_resp_valid_o,
  output logic                    load_err_o,
  output logic                    store_err_o,
  output logic                    busy_o,

  // data bus
  output logic                    data_req_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic                    data_err_i,
  output lsu_bus_pkg::addr_t      data_addr_o,
  output logic                    data_we_o,
  output lsu_bus_pkg::be_t        data_be_o,
  output lsu_bus_pkg::word_t      data_wdata_o,
  input  lsu_bus_pkg::word_t      data_rdata_i
);

  import lsu_bus_pkg::*;

  addr_t   data_addr_aligned;
  offset_t offset;
  logic    split;
  logic    second_part;
  logic    ctrl_update;
  logic    rdata_update;

  // bus address is always the word-aligned one
  assign data_addr_o = data_addr_aligned;
  assign data_we_o   = lsu_we_i;

  lsu_req_align lsu_req_align_inst (
    .adder_result_ex_i   (adder_result_ex_i),
    .lsu_type_i          (lsu_type_i),
    .lsu_wdata_i         (lsu_wdata_i),
    .second_part_i       (second_part),
    .data_be_o           (data_be_o),
    .data_wdata_o        (data_wdata_o),
    .data_addr_aligned_o (data_addr_aligned),
    .split_o             (split),
    .offset_o            (offset)
  );

  lsu_rdata_align lsu_rdata_align_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ctrl_update_i  (ctrl_update),
    .rdata_update_i (rdata_update),
    .offset_i       (offset),
    .lsu_type_i     (lsu_type_i),
    .lsu_sign_ext_i (lsu_sign_ext_i),
    .data_rdata_i   (data_rdata_i),
    .lsu_rdata_o    (lsu_rdata_o)
  );

  lsu_ctrl_fsm lsu_ctrl_fsm_inst (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .lsu_req_i           (lsu_req_i),
    .lsu_we_i            (lsu_we_i),
    .split_i             (split),
    .data_addr_i         (adder_result_ex_i),
    .data_addr_aligned_i (data_addr_aligned),
    .data_gnt_i          (data_gnt_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_err_i          (data_err_i),
    .data_req_o          (data_req_o),
    .addr_incr_req_o     (addr_incr_req_o),
    .second_part_o       (second_part),
    .ctrl_update_o       (ctrl_update),
    .rdata_update_o      (rdata_update),
    .addr_last_o         (addr_last_o),
    .lsu_req_done_o      (lsu_req_done_o),
    .lsu_resp_valid_o    (lsu_resp_valid_o),
    .lsu_rdata_valid_o   (lsu_rdata_valid_o),
    .load_err_o          (load_err_o),
    .store_err_o         (store_err_o),
    .busy_o              (busy_o)
  );

endmodule

`default_nettype wire

// ==== tb/lsu_asserts.sv ====
/*
 * Bus protocol checks for the load/store unit, bound into the top level.
 * Requests held until granted, nonzero enables, busy only with a core request.
 */

`default_nettype none

module lsu_asserts (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               lsu_req_i,
  input logic               data_req_o,
  input logic               data_gnt_i,
  input logic               data_we_o,
  input lsu_bus_pkg::addr_t data_addr_o,
  input lsu_bus_pkg::be_t   data_be_o,
  input lsu_bus_pkg::word_t data_wdata_o,
  input logic               busy_o
);

  // request keeps its address, enables and data until granted
  req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (data_req_o && !data_gnt_i) |=> (data_req_o && $stable(data_addr_o) &&
      $stable(data_be_o) && $stable(data_we_o) && $stable(data_wdata_o)))
    else $error("bus request changed before its grant");

  be_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o |-> (data_be_o != '0))
    else $error("request with no byte enabled");

  // sequencer leaves idle only before the core sees its request done
  busy_req_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_o |-> lsu_req_i)
    else $error("unit busy without a pending core request");

endmodule

bind lsu_top lsu_asserts lsu_asserts_inst (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .lsu_req_i    (lsu_req_i),
  .data_req_o   (data_req_o),
  .data_gnt_i   (data_gnt_i),
  .data_we_o    (data_we_o),
  .data_addr_o  (data_addr_o),
  .data_be_o    (data_be_o),
  .data_wdata_o (data_wdata_o),
  .busy_o       (busy_o)
);

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
/*
 * Clock and reset source for the load/store unit testbench.
 * 10-unit clock, reset held low for the first 16 cycles.
 */

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after an edge, away from the sampling point
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/tb_lsu.sv ====
/*
 * Testbench top for the load/store unit. Runs a table of loads and stores
 * against a bus memory model, predicts results from its own byte array
 * and reports each test, then the totals.
 */

`default_nettype none

module tb_lsu;

  import lsu_bus_pkg::*;
  import lsu_ctrl_pkg::*;

  localparam addr_t ERR_WORD = 32'h0000_0080;

  typedef struct packed {
    logic      we;
    lsu_type_e typ;
    logic      sext;
    addr_t     addr;
    word_t     wdata;
    logic      err;
  } entry_t;

  logic      clk, rst_n;
  logic      lsu_req, lsu_we, lsu_sign_ext;
  lsu_type_e lsu_type;
  word_t     lsu_wdata, lsu_rdata, data_wdata, data_rdata;
  addr_t     adder_result, addr_last, data_addr;
  logic      rdata_valid, addr_incr_req, req_done, resp_valid;
  logic      load_err, store_err, busy;
  logic      data_req, data_gnt, data_rvalid, data_err, data_we;
  be_t       data_be;

  entry_t     tests[$];
  logic [7:0] ref_mem [0:255];
  int         errors;
  int         timeout;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top lsu_top_inst (
    .clk_i (clk), .rst_n_i (rst_n),
    .lsu_req_i (lsu_req), .lsu_we_i (lsu_we), .lsu_type_i (lsu_type),
    .lsu_wdata_i (lsu_wdata), .lsu_sign_ext_i (lsu_sign_ext),
    .adder_result_ex_i (adder_result), .lsu_rdata_o (lsu_rdata),
    .lsu_rdata_valid_o (rdata_valid), .addr_incr_req_o (addr_incr_req),
    .addr_last_o (addr_last), .lsu_req_done_o (req_done),
    .lsu_resp_valid_o (resp_valid), .load_err_o (load_err),
    .store_err_o (store_err), .busy_o (busy),
    .data_req_o (data_req), .data_gnt_i (data_gnt), .data_rvalid_i (data_rvalid),
    .data_err_i (data_err), .data_addr_o (data_addr), .data_we_o (data_we),
    .data_be_o (data_be), .data_wdata_o (data_wdata), .data_rdata_i (data_rdata)
  );

  tb_lsu_mem tb_lsu_mem_inst (
    .clk_i (clk), .rst_n_i (rst_n), .req_i (data_req), .we_i (data_we),
    .addr_i (data_addr), .be_i (data_be), .wdata_i (data_wdata),
    .gnt_o (data_gnt), .rvalid_o (data_rvalid), .err_o (data_err),
    .rdata_o (data_rdata)
  );

  task automatic add_entry(input logic we, input lsu_type_e typ, input logic sext,
                           input addr_t addr, input word_t wdata, input logic err);
    entry_t e;
    e = '{we: we, typ: typ, sext: sext, addr: addr, wdata: wdata, err: err};
    tests.push_back(e);
  endtask

  function automatic int size_of(input lsu_type_e typ);
    return (typ == LSU_WORD) ? 4 : (typ == LSU_HALF) ? 2 : 1;
  endfunction

  // value a load should return, built byte by byte from the reference array
  function automatic word_t expect_load(input entry_t e);
    word_t w;
    w = '0;
    for (int k = 0; k < size_of(e.typ); k++) begin
      w[8*k +: 8] = ref_mem[8'(e.addr + k)];
    end
    if (e.sext && e.typ == LSU_HALF && w[15]) w[31:16] = 16'hffff;
    if (e.sext && e.typ != LSU_HALF && e.typ != LSU_WORD && w[7]) w[31:8] = 24'hffffff;
    return w;
  endfunction

  // store into the reference copy, skipping bytes of the error word
  task automatic apply_store(input entry_t e);
    addr_t a;
    for (int k = 0; k < size_of(e.typ); k++) begin
      a = e.addr + k;
      if ((a & ~addr_t'(3)) != ERR_WORD) ref_mem[a[7:0]] = e.wdata[8*k +: 8];
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one table entry
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_entry(input int idx, input entry_t e);
    int    done_cnt;
    int    err_before;
    logic  resp_seen;
    word_t got_rdata, exp_rdata;
    logic  got_rv, got_lerr, got_serr;
    addr_t got_last, exp_last;
    done_cnt   = 0;
    resp_seen  = 1'b0;
    err_before = errors;
    exp_rdata  = expect_load(e);
    assert (busy == 1'b0) else begin
      $display("test %0d: unit busy before the request", idx);
      errors++;
    end
    lsu_req      = 1'b1;
    lsu_we       = e.we;
    lsu_type     = e.typ;
    lsu_sign_ext = e.sext;
    lsu_wdata    = e.wdata;
    adder_result = e.addr;
    while (!resp_seen) begin
      @(negedge clk);
      if (req_done) done_cnt++;
      if (resp_valid) begin
        resp_seen = 1'b1;
        got_rdata = lsu_rdata;
        got_rv    = rdata_valid;
        got_lerr  = load_err;
        got_serr  = store_err;
        got_last  = addr_last;
      end
      @(posedge clk);
      #1;
      if (done_cnt > 0) lsu_req = 1'b0;
      // next word while the second half is asked for, same byte offset
      adder_result = addr_incr_req ? (e.addr + 32'd4) : e.addr;
    end
    assert (done_cnt == 1) else begin
      $display("test %0d: request done seen %0d times before the response", idx, done_cnt);
      errors++;
    end
    assert (got_lerr == (e.err & ~e.we)) else begin
      $display("MISMATCH t=%0t load_err_o got %b exp %b", $time, got_lerr, e.err & ~e.we);
      errors++;
    end
    assert (got_serr == (e.err & e.we)) else begin
      $display("MISMATCH t=%0t store_err_o got %b exp %b", $time, got_serr, e.err & e.we);
      errors++;
    end
    assert (got_rv == (~e.err & ~e.we)) else begin
      $display("MISMATCH t=%0t lsu_rdata_valid_o got %b exp %b", $time, got_rv,
               ~e.err & ~e.we);
      errors++;
    end
    if (!e.we && !e.err) begin
      assert (got_rdata == exp_rdata) else begin
        $display("MISMATCH t=%0t lsu_rdata_o got %h exp %h", $time, got_rdata, exp_rdata);
        errors++;
      end
    end
    if (e.err) begin
      // first word failing gives the raw address, else the second word
      exp_last = ((e.addr & ~addr_t'(3)) == ERR_WORD) ? e.addr : ERR_WORD;
      assert (got_last == exp_last) else begin
        $display("MISMATCH t=%0t addr_last_o got %h exp %h", $time, got_last, exp_last);
        errors++;
      end
    end
    if (e.we) apply_store(e);
    $display("test %0d %s addr %h: %s", idx, e.we ? "store" : "load", e.addr,
             (errors == err_before) ? "ok" : "FAILED");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    // aligned word round trip
    add_entry(1, LSU_WORD, 0, 32'h40, 32'hdeadbeef, 0);
    add_entry(0, LSU_WORD, 0, 32'h40, 32'h0, 0);
    // byte and halfword loads, both extension modes
    for (int o = 0; o < 4; o++) begin
      add_entry(0, LSU_BYTE, 0, 32'h20 + o, 32'h0, 0);
      add_entry(0, LSU_BYTE_ALT, 1, 32'h24 + o, 32'h0, 0);
      add_entry(0, LSU_HALF, o[0], 32'h28 + o, 32'h0, 0);
      add_entry(0, LSU_HALF, ~o[0], 32'h2c + o, 32'h0, 0);
    end
    // misaligned stores, loaded back and checked with aligned neighbours
    for (int o = 1; o < 4; o++) begin
      add_entry(1, LSU_WORD, 0, 32'h50 + 8 * o + o, 32'h8a71c3e0 + o, 0);
      add_entry(0, LSU_WORD, 0, 32'h50 + 8 * o + o, 32'h0, 0);
      add_entry(0, LSU_WORD, 0, 32'h50 + 8 * o, 32'h0, 0);
      add_entry(0, LSU_WORD, 0, 32'h54 + 8 * o, 32'h0, 0);
    end
    add_entry(1, LSU_HALF, 0, 32'h47, 32'h0000f00d, 0);
    add_entry(0, LSU_HALF, 1, 32'h47, 32'h0, 0);
    add_entry(0, LSU_WORD, 0, 32'h44, 32'h0, 0);
    add_entry(0, LSU_WORD, 0, 32'h48, 32'h0, 0);
    // bus errors on the marked word
    add_entry(0, LSU_WORD, 0, 32'h80, 32'h0, 1);
    add_entry(1, LSU_BYTE, 0, 32'h81, 32'h55, 1);
    add_entry(0, LSU_WORD, 0, 32'h7e, 32'h0, 1);
    add_entry(1, LSU_WORD, 0, 32'h83, 32'h12345678, 1);
    add_entry(0, LSU_WORD, 0, 32'h7c, 32'h0, 0);
    add_entry(0, LSU_WORD, 0, 32'h84, 32'h0, 0);
  end

  // 40 cycles per entry on top of the reset
  initial begin
    #1;
    timeout = (16 + 40 * tests.size()) * 10;
    #(timeout);
    $display("watchdog expired, the unit stopped answering");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    errors       = 0;
    lsu_req      = 1'b0;
    lsu_we       = 1'b0;
    lsu_type     = LSU_WORD;
    lsu_sign_ext = 1'b0;
    lsu_wdata    = '0;
    adder_result = '0;
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = 8'((i * 37 + 90) & 8'hff);
    end
    @(posedge rst_n);
    @(posedge clk);
    #1;
    foreach (tests[i]) begin
      run_entry(i, tests[i]);
    end
    $display("tests %0d, errors %0d", tests.size(), errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_lsu_mem.sv ====
/*
 * Byte-addressed data memory on the req/gnt/rvalid bus. Grants after a
 * random 0 to 2 cycle wait, answers one cycle later, and flags one word
 * as a bus error that is never written.
 */

`default_nettype none

module tb_lsu_mem (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  logic               we_i,
  input  lsu_bus_pkg::addr_t addr_i,
  input  lsu_bus_pkg::be_t   be_i,
  input  lsu_bus_pkg::word_t wdata_i,
  output logic               gnt_o,
  output logic               rvalid_o,
  output logic               err_o,
  output lsu_bus_pkg::word_t rdata_o
);

  import lsu_bus_pkg::*;

  localparam addr_t ERR_WORD = 32'h0000_0080;

  logic [7:0] mem [0:255];
  // grant wait of each request in turn
  logic [1:0] wait_tbl [0:255];
  logic [7:0] wait_idx_q;
  // cycles the current request has waited, and the wait it needs
  logic [1:0] cnt_q;
  logic [1:0] delay_q;
  logic       hit_err;
  logic [7:0] base;

  // same fill rule as the reference copy in the testbench
  initial begin
    void'($urandom(32'he158));
    for (int i = 0; i < 256; i++) begin
      mem[i]      = 8'((i * 37 + 90) & 8'hff);
      wait_tbl[i] = 2'($urandom_range(2, 0));
    end
  end

  assign gnt_o   = req_i && (cnt_q == delay_q);
  assign hit_err = ((addr_i & ~addr_t'(3)) == ERR_WORD);
  assign base    = {addr_i[7:2], 2'b00};

  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      delay_q    <= '0;
      wait_idx_q <= '0;
      rvalid_o   <= 1'b0;
      err_o      <= 1'b0;
      rdata_o    <= '0;
    end else begin
      rvalid_o <= 1'b0;
      err_o    <= 1'b0;
      if (gnt_o) begin
        cnt_q      <= '0;
        delay_q    <= wait_tbl[wait_idx_q];
        wait_idx_q <= wait_idx_q + 8'd1;
        rvalid_o   <= 1'b1;
        err_o      <= hit_err;
        rdata_o    <= {mem[base+3], mem[base+2], mem[base+1], mem[base]};
        // error word keeps its contents
        if (we_i && !hit_err) begin
          for (int b = 0; b < 4; b++) begin
            if (be_i[b]) mem[base+b] <= wdata_i[8*b +: 8];
          end
        end
      end else if (req_i) begin
        cnt_q <= cnt_q + 2'd1;
      end else begin
        cnt_q <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/lsu_bus_pkg.sv
src/lsu_ctrl_pkg.sv
src/lsu_req_align.sv
src/lsu_rdata_align.sv
src/lsu_ctrl_fsm.sv
src/lsu_top.sv
tb/tb_clk_gen.sv
tb/tb_lsu_mem.sv
tb/lsu_asserts.sv
tb/tb_lsu.sv
